/* src/vid_pkg.sv */
/*
 * Video subsystem shared definitions
 * Screen geometry, pipeline latency, the pixel structs passed
 * between the stages and the road register map
 */
package vid_pkg;

    // Horizontal geometry, in pixels
    localparam logic [8:0] h_total      = 9'd320;
    localparam logic [8:0] h_visible    = 9'd256;
    localparam logic [8:0] h_sync_start = 9'd272;
    localparam logic [8:0] h_sync_end   = 9'd296;

    // Vertical geometry, in lines
    localparam logic [8:0] v_total      = 9'd262;
    localparam logic [8:0] v_visible    = 9'd224;
    localparam logic [8:0] v_sync_start = 9'd234;
    localparam logic [8:0] v_sync_end   = 9'd237;

    // Strobes from timing position to RGB: char 2, road 1, mixer 2
    localparam int pipe_dly = 5;

    // Lines that pull the line interrupt low
    localparam logic [2:0][8:0] line_int_lines = {9'd192, 9'd128, 9'd64};

    // One pixel position with its blanking and sync levels
    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
        logic       hb;
        logic       vb;
        logic       hs;
        logic       vs;
    } vid_pos_t;

    // Char layer result, pixel 0 is transparent
    typedef struct packed {
        vid_pos_t   pos;
        logic [3:0] char_pix;
        logic [2:0] char_color;
    } char_pxl_t;

    // Both layers side by side, as seen by the mixer
    typedef struct packed {
        vid_pos_t   pos;
        logic [3:0] char_pix;
        logic [2:0] char_color;
        logic [6:0] road_idx;
    } layer_pxl_t;

    // Road register map
    typedef enum logic [1:0] {
        road_left   = 2'd0,
        road_right  = 2'd1,
        road_color  = 2'd2,
        grass_color = 2'd3
    } road_reg_e;

endpackage

/* src/vid_timing.sv */
/*
 * Video timing generator
 * Pixel and line counters advanced by pxl_cen, with blanking,
 * syncs and a line interrupt aligned to the registered position
 */
module vid_timing (
    input  logic              rst,
    input  logic              clk,
    input  logic              pxl_cen,
    output vid_pkg::vid_pos_t pos,
    output logic [8:0]        vdump,
    output logic              line_intn
);
    import vid_pkg::*;

    logic [8:0] h_nxt;
    logic [8:0] v_nxt;
    logic       h_wrap;

    function automatic logic is_int_line(input logic [8:0] v);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (v == line_int_lines[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Next count, the line advances when h wraps
    always_comb begin
        h_wrap = pos.h == h_total - 9'd1;
        h_nxt  = h_wrap ? 9'd0 : pos.h + 9'd1;
        v_nxt  = pos.v;
        if (h_wrap) begin
            v_nxt = (pos.v == v_total - 9'd1) ? 9'd0 : pos.v + 9'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos       <= '0;
            line_intn <= 1'b1;
        end else if (pxl_cen) begin
            pos.h     <= h_nxt;
            pos.v     <= v_nxt;
            pos.hb    <= h_nxt >= h_visible;
            pos.vb    <= v_nxt >= v_visible;
            pos.hs    <= h_nxt >= h_sync_start && h_nxt < h_sync_end;
            pos.vs    <= v_nxt >= v_sync_start && v_nxt < v_sync_end;
            // Low for the whole line
            line_intn <= !is_int_line(v_nxt);
        end
    end

    assign vdump = pos.v;

endmodule

/* src/vid_char_layer.sv */
/*
 * Fixed character layer
 * Tile RAM shared with the CPU, one strobe to read the tile word
 * and request the pattern row, one strobe to pick the pixel nibble
 */
module vid_char_layer (
    input  logic               rst,
    input  logic               clk,
    input  logic               pxl_cen,
    input  vid_pkg::vid_pos_t  pos_in,
    input  logic [9:0]         cpu_addr,
    input  logic [15:0]        cpu_dout,
    input  logic               cpu_we,
    input  logic               char_cs,
    output logic [15:0]        char_dout,
    output logic [11:0]        char_addr,
    input  logic [31:0]        char_data,
    output vid_pkg::char_pxl_t pxl
);
    import vid_pkg::*;

    logic [15:0] vram [1024];
    logic [9:0]  tile_addr;
    logic [11:0] tile_word;
    vid_pos_t    pos1;
    logic [3:0]  nibble;

    // CPU side of the tile RAM
    always_ff @(posedge clk) begin
        if (char_cs) begin
            if (cpu_we) begin
                vram[cpu_addr] <= cpu_dout;
            end else begin
                char_dout <= vram[cpu_addr];
            end
        end
    end

    // 32x32 tile map, row from v and column from h
    assign tile_addr = {pos_in.v[7:3], pos_in.h[7:3]};

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            tile_word <= vram[tile_addr][11:0];
        end
    end

    // Tile code and row within the tile
    assign char_addr = {tile_word[8:0], pos1.v[2:0]};

    // Leftmost pixel sits in the lowest nibble
    assign nibble = char_data[{pos1.h[2:0], 2'b00} +: 4];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos1 <= '0;
            pxl  <= '0;
        end else if (pxl_cen) begin
            pos1           <= pos_in;
            pxl.pos        <= pos1;
            pxl.char_pix   <= nibble;
            pxl.char_color <= tile_word[11:9];
        end
    end

endmodule

/* src/vid_road_layer.sv */
/*
 * Road layer
 * A striped road band between two CPU set edges over a grass
 * colour, registered next to the char layer data
 */
module vid_road_layer (
    input  logic                rst,
    input  logic                clk,
    input  logic                pxl_cen,
    input  vid_pkg::char_pxl_t  pxl_in,
    input  logic [9:0]          cpu_addr,
    input  logic [15:0]         cpu_dout,
    input  logic                cpu_we,
    input  logic                road_cs,
    input  logic                layer_en_road,
    output vid_pkg::layer_pxl_t pxl
);
    import vid_pkg::*;

    logic [8:0] left_edge;
    logic [8:0] right_edge;
    logic [6:0] road_col;
    logic [6:0] grass_col;
    logic       in_road;
    logic [6:0] idx;

    // Write-only registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left_edge  <= '0;
            right_edge <= '0;
            road_col   <= '0;
            grass_col  <= '0;
        end else if (road_cs && cpu_we) begin
            case (road_reg_e'(cpu_addr[1:0]))
                road_left:   left_edge  <= cpu_dout[8:0];
                road_right:  right_edge <= cpu_dout[8:0];
                road_color:  road_col   <= cpu_dout[6:0];
                grass_color: grass_col  <= cpu_dout[6:0];
            endcase
        end
    end

    // Both edges belong to the road
    assign in_road = pxl_in.pos.h >= left_edge && pxl_in.pos.h <= right_edge;

    always_comb begin
        if (!layer_en_road) begin
            idx = 7'd0;
        end else if (in_road) begin
            // Stripes alternate every 8 lines
            idx = road_col ^ {6'd0, pxl_in.pos.v[3]};
        end else begin
            idx = grass_col;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl.pos        <= pxl_in.pos;
            pxl.char_pix   <= pxl_in.char_pix;
            pxl.char_color <= pxl_in.char_color;
            pxl.road_idx   <= idx;
        end
    end

endmodule

/* src/vid_colmix.sv */
/*
 * Colour mixer
 * Picks the char or road layer, looks the result up in the
 * palette RAM and registers blanked RGB with syncs and blanking
 */
module vid_colmix (
    input  logic                rst,
    input  logic                clk,
    input  logic                pxl_cen,
    input  vid_pkg::layer_pxl_t pxl_in,
    input  logic                layer_en_char,
    input  logic [9:0]          cpu_addr,
    input  logic [15:0]         cpu_dout,
    input  logic                cpu_we,
    input  logic                pal_cs,
    output logic [15:0]         pal_dout,
    output logic                hs,
    output logic                vs,
    output logic                lhbl,
    output logic                lvbl,
    output logic [4:0]          red,
    output logic [4:0]          green,
    output logic [4:0]          blue
);
    import vid_pkg::*;

    logic [15:0] pal [256];
    logic [7:0]  pal_idx;
    logic [14:0] pal_word;
    vid_pos_t    pos1;

    // CPU side of the palette
    always_ff @(posedge clk) begin
        if (pal_cs) begin
            if (cpu_we) begin
                pal[cpu_addr[7:0]] <= cpu_dout;
            end else begin
                pal_dout <= pal[cpu_addr[7:0]];
            end
        end
    end

    // Char on top unless transparent, upper half of the palette
    assign pal_idx = (layer_en_char && pxl_in.char_pix != 4'd0) ?
                     {1'b1, pxl_in.char_color, pxl_in.char_pix} :
                     {1'b0, pxl_in.road_idx};

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_word <= pal[pal_idx][14:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos1  <= '0;
            hs    <= 1'b0;
            vs    <= 1'b0;
            lhbl  <= 1'b0;
            lvbl  <= 1'b0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            pos1 <= pxl_in.pos;
            hs   <= pos1.hs;
            vs   <= pos1.vs;
            lhbl <= !pos1.hb;
            lvbl <= !pos1.vb;
            if (pos1.hb || pos1.vb) begin
                {blue, green, red} <= '0;
            end else begin
                {blue, green, red} <= pal_word;
            end
        end
    end

endmodule

/* src/vid_top.sv */
/*
 * Video subsystem top level
 * Timing generator followed by the char layer, the road layer
 * and the colour mixer
 */
module vid_top (
    input  logic        rst,
    input  logic        clk,
    input  logic        pxl_cen,
    input  logic [1:0]  layer_en,
    input  logic [9:0]  cpu_addr,
    input  logic [15:0] cpu_dout,
    input  logic        cpu_we,
    input  logic        char_cs,
    input  logic        pal_cs,
    input  logic        road_cs,
    output logic [15:0] char_dout,
    output logic [15:0] pal_dout,
    output logic [11:0] char_addr,
    input  logic [31:0] char_data,
    output logic        hs,
    output logic        vs,
    output logic        lhbl,
    output logic        lvbl,
    output logic [8:0]  vdump,
    output logic        line_intn,
    output logic [4:0]  red,
    output logic [4:0]  green,
    output logic [4:0]  blue
);
    import vid_pkg::*;

    vid_pos_t   pos;
    char_pxl_t  char_pxl;
    layer_pxl_t layer_pxl;

    vid_timing u_timing (
        .rst       ( rst       ),
        .clk       ( clk       ),
        .pxl_cen   ( pxl_cen   ),
        .pos       ( pos       ),
        .vdump     ( vdump     ),
        .line_intn ( line_intn )
    );

    vid_char_layer u_char (
        .rst       ( rst       ),
        .clk       ( clk       ),
        .pxl_cen   ( pxl_cen   ),
        .pos_in    ( pos       ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_we    ( cpu_we    ),
        .char_cs   ( char_cs   ),
        .char_dout ( char_dout ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .pxl       ( char_pxl  )
    );

    // Bit 1 enables the road
    vid_road_layer u_road (
        .rst           ( rst         ),
        .clk           ( clk         ),
        .pxl_cen       ( pxl_cen     ),
        .pxl_in        ( char_pxl    ),
        .cpu_addr      ( cpu_addr    ),
        .cpu_dout      ( cpu_dout    ),
        .cpu_we        ( cpu_we      ),
        .road_cs       ( road_cs     ),
        .layer_en_road ( layer_en[1] ),
        .pxl           ( layer_pxl   )
    );

    vid_colmix u_colmix (
        .rst           ( rst         ),
        .clk           ( clk         ),
        .pxl_cen       ( pxl_cen     ),
        .pxl_in        ( layer_pxl   ),
        .layer_en_char ( layer_en[0] ),
        .cpu_addr      ( cpu_addr    ),
        .cpu_dout      ( cpu_dout    ),
        .cpu_we        ( cpu_we      ),
        .pal_cs        ( pal_cs      ),
        .pal_dout      ( pal_dout    ),
        .hs            ( hs          ),
        .vs            ( vs          ),
        .lhbl          ( lhbl        ),
        .lvbl          ( lvbl        ),
        .red           ( red         ),
        .green         ( green       ),
        .blue          ( blue        )
    );

endmodule

/* testbench/tb_vid_top.sv */
/*
 * Testbench for the video subsystem
 * Random tile RAM, palette, road and pattern ROM contents, checked
 * against a model of the picture that follows the output counters
 */
module tb_vid_top;
    timeunit 1ns;
    timeprecision 1ps;
    import vid_pkg::*;

    localparam int frame_strobes = int'(v_total) * int'(h_total);
    localparam int frame_pixels  = int'(v_visible) * int'(h_visible);

    logic        rst;
    logic        clk;
    logic        pxl_cen;
    logic [1:0]  layer_en;
    logic [9:0]  cpu_addr;
    logic [15:0] cpu_dout;
    logic        cpu_we;
    logic        char_cs;
    logic        pal_cs;
    logic        road_cs;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [11:0] char_addr;
    logic [31:0] char_data;
    logic        hs;
    logic        vs;
    logic        lhbl;
    logic        lvbl;
    logic [8:0]  vdump;
    logic        line_intn;
    logic [4:0]  red;
    logic [4:0]  green;
    logic [4:0]  blue;

    // Pattern ROM and mirrors of the CPU side memories
    logic [31:0] rom [4096];
    logic [15:0] tile_mem [1024];
    logic [15:0] pal_mem [256];
    logic [8:0]  road_l;
    logic [8:0]  road_r;
    logic [6:0]  road_c;
    logic [6:0]  grass_c;

    integer seed = 32'hda32eb82;
    int     n_errors = 0;
    int     n_checks = 0;
    int     n_pix = 0;
    bit     check_en = 1'b0;
    bit     synced = 1'b0;
    int     x = 0;
    int     y = 0;
    logic   prev_lhbl = 1'b0;
    logic   prev_lvbl = 1'b0;

    vid_top dut (
        .rst       ( rst       ),
        .clk       ( clk       ),
        .pxl_cen   ( pxl_cen   ),
        .layer_en  ( layer_en  ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_we    ( cpu_we    ),
        .char_cs   ( char_cs   ),
        .pal_cs    ( pal_cs    ),
        .road_cs   ( road_cs   ),
        .char_dout ( char_dout ),
        .pal_dout  ( pal_dout  ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .vdump     ( vdump     ),
        .line_intn ( line_intn ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Pixel strobe every other clock
    always @(negedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    // Pattern ROM, read data launched on the falling edge
    always @(negedge clk) begin
        char_data <= rom[char_addr];
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp,
                         input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic timeout(input string what);
        $display("Timeout while waiting for %s", what);
        n_errors++;
        finish_run();
    endtask

    // Expected colour of visible pixel (px, py)
    function automatic logic [14:0] expect_rgb(input int px, input int py);
        logic [15:0] tile;
        logic [31:0] row;
        logic [3:0]  nib;
        logic        stripe;
        logic [6:0]  ridx;
        logic [7:0]  pidx;
        tile   = tile_mem[(py / 8) * 32 + px / 8];
        row    = rom[int'(tile[8:0]) * 8 + py % 8];
        nib    = row[(px % 8) * 4 +: 4];
        stripe = (py / 8) % 2 != 0;
        if (!layer_en[1]) begin
            ridx = 7'd0;
        end else if (px >= road_l && px <= road_r) begin
            ridx = road_c ^ {6'd0, stripe};
        end else begin
            ridx = grass_c;
        end
        pidx = (layer_en[0] && nib != 4'd0) ? {1'b1, tile[11:9], nib} : {1'b0, ridx};
        return pal_mem[pidx][14:0];
    endfunction

    // Output side monitor, one pass per strobe
    initial begin
        forever begin
            @(posedge clk);
            if (pxl_cen && !rst) begin
                @(negedge clk);
                check(line_intn, !(vdump == 9'd64 || vdump == 9'd128 || vdump == 9'd192),
                      "line_intn");
                if (lhbl && !prev_lhbl) begin
                    x = 0;
                    y = (lvbl && !prev_lvbl) ? 0 : y + 1;
                    synced = synced || (lvbl && !prev_lvbl);
                end else begin
                    x = x + 1;
                end
                // Syncs share the output delay, vdump runs pipe_dly strobes ahead
                if (check_en && synced) begin
                    check(hs, x >= h_sync_start && x < h_sync_end, "hs");
                    check(vs, y >= v_sync_start && y < v_sync_end, "vs");
                    check(vdump, (x + pipe_dly >= int'(h_total)) ? (y + 1) % int'(v_total) : y,
                          "vdump");
                end
                if (check_en && (!lhbl || !lvbl)) begin
                    check({blue, green, red}, 0, "blanked RGB");
                end else if (check_en && synced) begin
                    check({blue, green, red}, expect_rgb(x, y),
                          $sformatf("RGB at %0d,%0d", x, y));
                    n_pix++;
                end
                prev_lhbl = lhbl;
                prev_lvbl = lvbl;
            end
        end
    end

    task automatic next_strobe();
        int n;
        n = 0;
        @(posedge clk);
        while (!pxl_cen && n < 4) begin
            n++;
            @(posedge clk);
        end
        if (!pxl_cen) timeout("the pixel strobe");
        @(negedge clk);
    endtask

    function automatic logic blank_level(input int which);
        return (which == 0) ? lhbl : lvbl;
    endfunction

    // which 0 is lhbl, 1 is lvbl
    task automatic wait_sig(input int which, input logic val, input string what);
        int n;
        n = 0;
        while (blank_level(which) !== val && n < 2 * frame_strobes) begin
            n++;
            next_strobe();
        end
        if (blank_level(which) !== val) timeout(what);
    endtask

    task automatic wait_vblank();
        int n;
        n = 0;
        while (!(vdump == v_visible && !lvbl) && n < 2 * frame_strobes) begin
            n++;
            next_strobe();
        end
        if (!(vdump == v_visible && !lvbl)) timeout("vertical blanking");
    endtask

    task automatic run_frames(input int frames);
        for (int i = 0; i < frames; i++) begin
            wait_sig(1, 1'b1, "the start of a frame");
            wait_sig(1, 1'b0, "the end of a frame");
        end
    endtask

    // Starts on the strobe where the level has just risen
    task automatic measure(input int which, output int high, output int period);
        int n;
        n = 1;
        next_strobe();
        while (blank_level(which) && n < 2 * frame_strobes) begin
            n++;
            next_strobe();
        end
        high = n;
        while (!blank_level(which) && n < 2 * frame_strobes) begin
            n++;
            next_strobe();
        end
        period = n;
        if (n >= 2 * frame_strobes) timeout("a blanking edge");
    endtask

    // sel 0 is the tile RAM, 1 the palette, 2 the road registers
    task automatic cpu_write(input int sel, input logic [9:0] addr, input logic [15:0] data);
        char_cs  = sel == 0;
        pal_cs   = sel == 1;
        road_cs  = sel == 2;
        cpu_we   = 1'b1;
        cpu_addr = addr;
        cpu_dout = data;
        @(negedge clk);
        {char_cs, pal_cs, road_cs, cpu_we} = 4'b0000;
    endtask

    task automatic cpu_read(input int sel, input logic [9:0] addr, output logic [15:0] data);
        char_cs  = sel == 0;
        pal_cs   = sel == 1;
        cpu_we   = 1'b0;
        cpu_addr = addr;
        @(negedge clk);
        data = (sel == 0) ? char_dout : pal_dout;
        {char_cs, pal_cs} = 2'b00;
    endtask

    task automatic load_memories();
        logic [15:0] d;
        for (int i = 0; i < 1024; i++) begin
            d = $random(seed);
            tile_mem[i] = d;
            cpu_write(0, 10'(i), d);
        end
        for (int i = 0; i < 256; i++) begin
            d = $random(seed);
            pal_mem[i] = d;
            cpu_write(1, 10'(i), d);
        end
    endtask

    task automatic load_road();
        logic [31:0] r;
        r       = $random(seed);
        road_l  = {1'b0, r[7:0]};
        road_r  = road_l + r[14:8];
        road_c  = r[21:15];
        grass_c = r[28:22];
        cpu_write(2, 10'(road_left), 16'(road_l));
        cpu_write(2, 10'(road_right), 16'(road_r));
        cpu_write(2, 10'(road_color), 16'(road_c));
        cpu_write(2, 10'(grass_color), 16'(grass_c));
    endtask

    initial begin
        int          hi;
        int          per;
        logic [31:0] r;
        logic [15:0] q;
        rst       = 1'b1;
        pxl_cen   = 1'b0;
        layer_en  = 2'b00;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_we    = 1'b0;
        char_cs   = 1'b0;
        pal_cs    = 1'b0;
        road_cs   = 1'b0;
        char_data = '0;
        {road_l, road_r, road_c, grass_c} = '0;
        for (int i = 0; i < 4096; i++) begin
            rom[i] = $random(seed);
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        check(line_intn, 1'b1, "line_intn after reset");
        check({hs, vs}, 2'b00, "syncs after reset");
        check({blue, green, red}, 0, "RGB after reset");

        // Line and frame timing, after the partial first frame
        wait_vblank();
        wait_sig(0, 1'b0, "horizontal blanking");
        wait_sig(0, 1'b1, "the start of a line");
        measure(0, hi, per);
        check(hi, h_visible, "visible strobes per line");
        check(per, h_total, "strobes per line");
        wait_sig(1, 1'b1, "the start of a frame");
        measure(1, hi, per);
        check(hi, int'(v_visible) * int'(h_total), "visible strobes per frame");
        check(per, frame_strobes, "strobes per frame");

        // Char layer alone
        wait_vblank();
        layer_en = 2'b01;
        load_memories();
        check_en = 1'b1;
        n_pix    = 0;
        run_frames(1);
        check(n_pix, frame_pixels, "pixels in the char frame");

        // Road layer alone
        wait_vblank();
        layer_en = 2'b10;
        load_road();
        n_pix = 0;
        run_frames(1);
        check(n_pix, frame_pixels, "pixels in the road frame");

        // Both layers over two frames
        wait_vblank();
        layer_en = 2'b11;
        load_memories();
        load_road();
        n_pix = 0;
        run_frames(2);
        check(n_pix, 2 * frame_pixels, "pixels in the mixed frames");

        // CPU writes and reads mixed at random
        check_en = 1'b0;
        for (int i = 0; i < 256; i++) begin
            r = $random(seed);
            if (r[1]) begin
                cpu_write(int'(r[0]), r[11:2], r[31:16]);
                if (r[0]) pal_mem[r[9:2]] = r[31:16];
                else tile_mem[r[11:2]] = r[31:16];
            end else begin
                cpu_read(int'(r[0]), r[11:2], q);
                check(q, r[0] ? pal_mem[r[9:2]] : tile_mem[r[11:2]], "CPU readback");
            end
        end
        finish_run();
    end

endmodule

/* verilog.f */
src/vid_pkg.sv
src/vid_timing.sv
src/vid_char_layer.sv
src/vid_road_layer.sv
src/vid_colmix.sv
src/vid_top.sv
testbench/tb_vid_top.sv

/* Bender.yml */
package:
  name: vid_subsystem

sources:
  - src/vid_pkg.sv
  - src/vid_timing.sv
  - src/vid_char_layer.sv
  - src/vid_road_layer.sv
  - src/vid_colmix.sv
  - src/vid_top.sv
  - target: test
    files:
      - testbench/tb_vid_top.sv
